// File: Bender.yml
package:
  name: dram_bridge

sources:
  - verilog/dram_bridge_pkg.sv
  - verilog/reset_sequencer.sv
  - verilog/dma_arbiter.sv
  - verilog/dram_channel_ctrl.sv
  - verilog/dram_model.sv
  - verilog/dram_bridge_top.sv
  - target: test
    files:
      - tests/dram_bridge_properties.sv
      - tests/dram_bridge_tb.sv

// File: src.f
verilog/dram_bridge_pkg.sv
verilog/reset_sequencer.sv
verilog/dma_arbiter.sv
verilog/dram_channel_ctrl.sv
verilog/dram_model.sv
verilog/dram_bridge_top.sv
tests/dram_bridge_properties.sv
tests/dram_bridge_tb.sv

// File: tests/dram_bridge_properties.sv
//////////////////////////////
// concurrent checks on reset sequencing and the DMA handshakes
// bound into dram_bridge_top
//////////////////////////////

`timescale 1ns/100ps

module dram_bridge_properties (
  input logic                                     clk_i,
  input logic                                     rst_i,
  input logic                                     core_rst_i,
  input logic                                     tag_done_i,
  input logic [dram_bridge_pkg::NUM_CACHES-1:0]   pkt_yumi_i,
  input logic [dram_bridge_pkg::NUM_CACHES-1:0]   data_yumi_i,
  input logic [dram_bridge_pkg::NUM_CACHES-1:0]   data_v_i,
  input logic [dram_bridge_pkg::NUM_CACHES-1:0]   data_ready_i,
  input logic [dram_bridge_pkg::DATA_W-1:0]       data_i
);

  import dram_bridge_pkg::*;

  int fail_cnt = 0;

  // core held in reset through the whole tag phase
  tag_phase_holds_core: assert property (@(posedge clk_i) disable iff (rst_i)
    !tag_done_i |-> core_rst_i)
    else begin
      fail_cnt++;
      $error("core reset released before tag programming ended");
    end

  tag_done_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
    tag_done_i |=> tag_done_i)
    else begin
      fail_cnt++;
      $error("tag_done dropped without a reset");
    end

  // release travels the whole reset chain
  core_release_delay: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(tag_done_i) |-> ##RESET_DEPTH $fell(core_rst_i))
    else begin
      fail_cnt++;
      $error("core reset did not fall the chain depth after tag_done rose");
    end

  quiet_in_core_reset: assert property (@(posedge clk_i) disable iff (rst_i)
    core_rst_i |-> (pkt_yumi_i == '0 && data_yumi_i == '0 && data_v_i == '0))
    else begin
      fail_cnt++;
      $error("handshake activity while the core is in reset");
    end

  // an accepted request makes the controller busy
  one_request_per_burst: assert property (@(posedge clk_i) disable iff (core_rst_i)
    (|pkt_yumi_i) |=> (pkt_yumi_i == '0))
    else begin
      fail_cnt++;
      $error("a request was accepted right after another one");
    end

  // stalled return word must not move
  read_hold: assert property (@(posedge clk_i) disable iff (core_rst_i)
    (|(data_v_i & ~data_ready_i)) |=> (data_v_i == $past(data_v_i) && data_i == $past(data_i)))
    else begin
      fail_cnt++;
      $error("read data changed while the owner was not ready");
    end

endmodule

bind dram_bridge_top dram_bridge_properties dram_bridge_properties_i (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .core_rst_i    (core_rst),
  .tag_done_i    (tag_done_o),
  .pkt_yumi_i    (dma_pkt_yumi_o),
  .data_yumi_i   (dma_data_yumi_o),
  .data_v_i      (dma_data_v_o),
  .data_ready_i  (dma_data_ready_i),
  .data_i        (dma_data_o)
);

// File: tests/dram_bridge_tb.sv
//////////////////////////////
// testbench for the vcache DMA to DRAM channel bridge
// reset release, write and read bursts, round-robin order,
// read back-pressure and bank aliasing against a scoreboard
//////////////////////////////

`timescale 1ns/100ps

module dram_bridge_tb;

  import dram_bridge_pkg::*;

  localparam int CLK_PERIOD      = 8;
  localparam int SAMPLE_DLY      = 2;
  localparam int SEED            = 30574;
  localparam int TIMEOUT_CYCLES  = 4000;
  localparam int BURSTS_PER_PORT = 4;
  localparam int BLK_LSB         = BO_W + BURST_CNT_W;

  logic                                 clk_i;
  logic                                 rst_i;
  logic                                 tag_done_o;
  dma_pkt_s [NUM_CACHES-1:0]            dma_pkt_i;
  logic [NUM_CACHES-1:0]                dma_pkt_v_i;
  logic [NUM_CACHES-1:0]                dma_pkt_yumi_o;
  logic [NUM_CACHES-1:0][DATA_W-1:0]    dma_data_i;
  logic [NUM_CACHES-1:0]                dma_data_v_i;
  logic [NUM_CACHES-1:0]                dma_data_yumi_o;
  logic [DATA_W-1:0]                    dma_data_o;
  logic [NUM_CACHES-1:0]                dma_data_v_o;
  logic [NUM_CACHES-1:0]                dma_data_ready_i;

  // expected memory contents by cache order word address
  logic [DATA_W-1:0] scoreboard [2**(ADDR_W-BO_W)];
  logic [ADDR_W-1:0] port_addr [NUM_CACHES][BURSTS_PER_PORT];
  int                mismatch_cnt;
  int                cycle_cnt;

  dram_bridge_top dram_bridge_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD/2) clk_i = ~clk_i;
  end

  task automatic expect_equal(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
    assert (act === exp) else begin
      $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, act);
      mismatch_cnt++;
    end
  endtask

  function automatic logic [ADDR_W-1:0] random_block();
    logic [ADDR_W-1:0] a;
    a = ADDR_W'($urandom);
    a[BLK_LSB-1:0] = '0;
    return a;
  endfunction

  // same row and column with bank and bank group taken from sel
  function automatic logic [ADDR_W-1:0] alias_addr(input logic [ADDR_W-1:0] base, input int sel);
    cache_addr_s ca;
    ca    = cache_addr_s'(base);
    ca.ba = BA_W'(sel >> BG_W);
    ca.bg = BG_W'(sel);
    return ca;
  endfunction

  function automatic int word_index(input logic [ADDR_W-1:0] base, input int k);
    return int'(base[ADDR_W-1:BO_W]) + k;
  endfunction

  // first valid port after the last winner with wraparound
  function automatic int next_grant(input int last, input logic [NUM_CACHES-1:0] valid);
    int idx;
    for (int i = 1; i <= NUM_CACHES; i++) begin
      idx = (last + i) % NUM_CACHES;
      if (valid[idx]) begin
        return idx;
      end
    end
    return 0;
  endfunction

  // returns in the sampling slot where the port sees its yumi
  task automatic wait_for_grant(input int port);
    #SAMPLE_DLY;
    while (!dma_pkt_yumi_o[port]) begin
      @(negedge clk_i);
      #SAMPLE_DLY;
    end
  endtask

  task automatic write_burst(input int port, input logic [ADDR_W-1:0] base);
    logic [DATA_W-1:0] word;
    int                k;
    k    = 0;
    word = $urandom;
    @(negedge clk_i);
    dma_pkt_i[port].write_not_read = 1'b1;
    dma_pkt_i[port].addr           = base;
    dma_pkt_v_i[port]              = 1'b1;
    wait_for_grant(port);
    @(negedge clk_i);
    dma_pkt_v_i[port]  = 1'b0;
    dma_data_i[port]   = word;
    dma_data_v_i[port] = 1'b1;
    while (k < BURST_LEN) begin
      #SAMPLE_DLY;
      if (dma_data_yumi_o[port]) begin
        scoreboard[word_index(base, k)] = word;
        k++;
        word = $urandom;
      end
      @(negedge clk_i);
      dma_data_i[port] = word;
    end
    dma_data_v_i[port] = 1'b0;
  endtask

  task automatic read_burst(input int port, input logic [ADDR_W-1:0] base, input bit stall);
    logic [DATA_W-1:0] held;
    logic              stalled;
    int                k;
    k       = 0;
    held    = '0;
    stalled = 1'b0;
    @(negedge clk_i);
    dma_pkt_i[port].write_not_read = 1'b0;
    dma_pkt_i[port].addr           = base;
    dma_pkt_v_i[port]              = 1'b1;
    wait_for_grant(port);
    @(negedge clk_i);
    dma_pkt_v_i[port] = 1'b0;
    while (k < BURST_LEN) begin
      dma_data_ready_i[port] = stall ? (($urandom % 2) == 1) : 1'b1;
      #SAMPLE_DLY;
      if (stalled) begin
        expect_equal("dma_data_v_o", 1, dma_data_v_o[port]);
        expect_equal("dma_data_o", held, dma_data_o);
      end
      stalled = 1'b0;
      if (dma_data_v_o[port]) begin
        if (dma_data_ready_i[port]) begin
          expect_equal("dma_data_o", scoreboard[word_index(base, k)], dma_data_o);
          k++;
        end else begin
          held    = dma_data_o;
          stalled = 1'b1;
        end
      end
      @(negedge clk_i);
    end
    dma_data_ready_i[port] = 1'b0;
  endtask

  task automatic write_series(input int port);
    for (int j = 0; j < BURSTS_PER_PORT; j++) begin
      port_addr[port][j] = random_block();
      write_burst(port, port_addr[port][j]);
    end
  endtask

  task automatic read_series(input int port);
    for (int j = 0; j < BURSTS_PER_PORT; j++) begin
      read_burst(port, port_addr[port][j], 1'b1);
    end
  endtask

  //////////////////////////////
  // grant order monitor
  //////////////////////////////

  initial begin : grant_order
    int last;
    bit have_last;
    last      = 0;
    have_last = 1'b0;
    forever begin
      @(negedge clk_i);
      #SAMPLE_DLY;
      if (dma_pkt_yumi_o != '0) begin
        if (have_last) begin
          expect_equal("dma_pkt_yumi_o", 1 << next_grant(last, dma_pkt_v_i), dma_pkt_yumi_o);
        end
        for (int i = 0; i < NUM_CACHES; i++) begin
          if (dma_pkt_yumi_o[i]) begin
            last = i;
          end
        end
        have_last = 1'b1;
      end
    end
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Verification failed");
    $finish;
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    logic [ADDR_W-1:0] base;
    int                prop_fails;
    void'($urandom(SEED));
    mismatch_cnt     = 0;
    rst_i            = 1'b1;
    dma_pkt_i        = '0;
    dma_pkt_v_i      = '1;
    dma_data_i       = '0;
    dma_data_v_i     = '1;
    dma_data_ready_i = '0;
    repeat (8) @(negedge clk_i);
    rst_i = 1'b0;

    // requests and write data stay pending through the release
    for (int n = 1; n <= TAG_PROG_CYCLES + RESET_DEPTH; n++) begin
      @(negedge clk_i);
      #SAMPLE_DLY;
      expect_equal("tag_done_o", 32'(n >= TAG_PROG_CYCLES), tag_done_o);
      expect_equal("dma_pkt_yumi_o", '0, dma_pkt_yumi_o);
      expect_equal("dma_data_yumi_o", '0, dma_data_yumi_o);
      expect_equal("dma_data_v_o", '0, dma_data_v_o);
    end
    @(negedge clk_i);
    dma_pkt_v_i  = '0;
    dma_data_v_i = '0;

    for (int p = 0; p < NUM_CACHES; p++) begin
      base = random_block();
      write_burst(p, base);
      read_burst(p, base, 1'b0);
    end

    // all ports compete and then read back under random back-pressure
    fork
      write_series(0);
      write_series(1);
      write_series(2);
      write_series(3);
    join
    fork
      read_series(0);
      read_series(1);
      read_series(2);
      read_series(3);
    join

    base = random_block();
    for (int i = 0; i < 2**(BA_W+BG_W); i++) begin
      write_burst(i % NUM_CACHES, alias_addr(base, i));
    end
    for (int i = 0; i < 2**(BA_W+BG_W); i++) begin
      read_burst((i + 1) % NUM_CACHES, alias_addr(base, i), 1'b0);
    end

    repeat (4) @(negedge clk_i);
    prop_fails = dram_bridge_top_i.dram_bridge_properties_i.fail_cnt;
    $display("checks done: %0d mismatches, %0d property failures", mismatch_cnt, prop_fails);
    if (mismatch_cnt == 0 && prop_fails == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: verilog/dma_arbiter.sv
//////////////////////////////
// round-robin choice among the vcache DMA request ports
// grants only while the channel controller is idle; the grant,
// the yumi pulse and the controller latch all happen in one cycle
//////////////////////////////

`timescale 1ns/100ps

module dma_arbiter (
  input  logic                                                         clk_i,
  input  logic                                                         core_rst_i,
  input  dram_bridge_pkg::dma_pkt_s [dram_bridge_pkg::NUM_CACHES-1:0]  dma_pkt_i,
  input  logic [dram_bridge_pkg::NUM_CACHES-1:0]                       dma_pkt_v_i,
  output logic [dram_bridge_pkg::NUM_CACHES-1:0]                       dma_pkt_yumi_o,
  input  logic                                                         busy_i,
  output logic                                                         req_v_o,
  output dram_bridge_pkg::dma_pkt_s                                    req_pkt_o,
  output logic [dram_bridge_pkg::CACHE_ID_W-1:0]                       req_id_o
);

  import dram_bridge_pkg::*;

  logic [CACHE_ID_W-1:0] ptr_r;
  logic                  active_r;
  logic [CACHE_ID_W-1:0] winner;
  logic                  found;

  // rotating priority search starting at the pointer
  always_comb begin
    found  = 1'b0;
    winner = ptr_r;
    for (int i = 0; i < NUM_CACHES; i++) begin
      logic [CACHE_ID_W-1:0] idx;
      idx = ptr_r + CACHE_ID_W'(i);
      if (!found && dma_pkt_v_i[idx]) begin
        found  = 1'b1;
        winner = idx;
      end
    end
  end

  assign req_v_o   = found && !busy_i && active_r;
  assign req_pkt_o = dma_pkt_i[winner];
  assign req_id_o  = winner;

  always_comb begin
    dma_pkt_yumi_o         = '0;
    dma_pkt_yumi_o[winner] = req_v_o;
  end

  //////////////////////////////
  // pointer and enable
  //////////////////////////////

  // next search begins just past the last winner
  always_ff @(posedge clk_i) begin
    if (core_rst_i) begin
      ptr_r    <= '0;
      active_r <= 1'b0;
    end else begin
      active_r <= 1'b1;
      if (req_v_o) begin
        ptr_r <= winner + 1'b1;
      end
    end
  end

endmodule

// File: verilog/dram_bridge_pkg.sv
//////////////////////////////
// shared definitions for the vcache DMA to DRAM channel bridge
// address field widths, packet structs and the controller FSM states
// modules pull this in with a wildcard import in their body
//////////////////////////////

package dram_bridge_pkg;

  // vcache DMA side
  localparam int NUM_CACHES = 4;
  localparam int CACHE_ID_W = 2;
  localparam int DATA_W     = 32;
  localparam int BURST_LEN  = 4;
  localparam int BURST_CNT_W = $clog2(BURST_LEN);

  // address fields, byte address of 14 bits
  localparam int BA_W = 2;
  localparam int BG_W = 1;
  localparam int RO_W = 6;
  localparam int CO_W = 3;
  localparam int BO_W = 2;
  localparam int ADDR_W = BA_W + BG_W + RO_W + CO_W + BO_W;

  // reset sequencing
  localparam int TAG_PROG_CYCLES = 16;
  localparam int RESET_DEPTH     = 3;

  typedef struct packed {
    logic              write_not_read;
    logic [ADDR_W-1:0] addr;
  } dma_pkt_s;

  // field order as the cache DMA produces it
  typedef struct packed {
    logic [BA_W-1:0] ba;
    logic [BG_W-1:0] bg;
    logic [RO_W-1:0] ro;
    logic [CO_W-1:0] co;
    logic [BO_W-1:0] bo;
  } cache_addr_s;

  // field order the channel expects
  typedef struct packed {
    logic [RO_W-1:0] ro;
    logic [BG_W-1:0] bg;
    logic [BA_W-1:0] ba;
    logic [CO_W-1:0] co;
    logic [BO_W-1:0] bo;
  } dram_addr_s;

  typedef struct packed {
    logic              write_not_read;
    dram_addr_s        addr;
    logic [DATA_W-1:0] data;
  } dram_req_s;

  typedef enum logic [1:0] {
    IDLE,
    WRITE_BURST,
    READ_BURST
  } ctrl_state_e;

endpackage

// File: verilog/dram_bridge_top.sv
//////////////////////////////
// vcache DMA ports to one DRAM channel
// reset sequencer, round-robin arbiter, burst controller and
// channel memory, connected here and nothing else
//////////////////////////////

`timescale 1ns/100ps

module dram_bridge_top (
  input  logic                                                        clk_i,
  input  logic                                                        rst_i,
  output logic                                                        tag_done_o,
  input  dram_bridge_pkg::dma_pkt_s [dram_bridge_pkg::NUM_CACHES-1:0] dma_pkt_i,
  input  logic [dram_bridge_pkg::NUM_CACHES-1:0]                      dma_pkt_v_i,
  output logic [dram_bridge_pkg::NUM_CACHES-1:0]                      dma_pkt_yumi_o,
  input  logic [dram_bridge_pkg::NUM_CACHES-1:0]
               [dram_bridge_pkg::DATA_W-1:0]                          dma_data_i,
  input  logic [dram_bridge_pkg::NUM_CACHES-1:0]                      dma_data_v_i,
  output logic [dram_bridge_pkg::NUM_CACHES-1:0]                      dma_data_yumi_o,
  output logic [dram_bridge_pkg::DATA_W-1:0]                          dma_data_o,
  output logic [dram_bridge_pkg::NUM_CACHES-1:0]                      dma_data_v_o,
  input  logic [dram_bridge_pkg::NUM_CACHES-1:0]                      dma_data_ready_i
);

  import dram_bridge_pkg::*;

  logic                  core_rst;
  logic                  busy;
  logic                  req_v;
  dma_pkt_s              req_pkt;
  logic [CACHE_ID_W-1:0] req_id;
  logic                  mem_req_v;
  dram_req_s             mem_req;
  logic [DATA_W-1:0]     mem_rdata;
  logic                  mem_rdata_v;
  dram_addr_s            mem_rdone_addr;

  reset_sequencer reset_sequencer_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .tag_done_o (tag_done_o),
    .core_rst_o (core_rst)
  );

  dma_arbiter dma_arbiter_i (
    .clk_i          (clk_i),
    .core_rst_i     (core_rst),
    .dma_pkt_i      (dma_pkt_i),
    .dma_pkt_v_i    (dma_pkt_v_i),
    .dma_pkt_yumi_o (dma_pkt_yumi_o),
    .busy_i         (busy),
    .req_v_o        (req_v),
    .req_pkt_o      (req_pkt),
    .req_id_o       (req_id)
  );

  dram_channel_ctrl dram_channel_ctrl_i (
    .clk_i            (clk_i),
    .core_rst_i       (core_rst),
    .req_v_i          (req_v),
    .req_pkt_i        (req_pkt),
    .req_id_i         (req_id),
    .busy_o           (busy),
    .dma_data_i       (dma_data_i),
    .dma_data_v_i     (dma_data_v_i),
    .dma_data_yumi_o  (dma_data_yumi_o),
    .dma_data_o       (dma_data_o),
    .dma_data_v_o     (dma_data_v_o),
    .dma_data_ready_i (dma_data_ready_i),
    .mem_req_v_o      (mem_req_v),
    .mem_req_o        (mem_req),
    .mem_rdata_i      (mem_rdata),
    .mem_rdata_v_i    (mem_rdata_v),
    .mem_rdone_addr_i (mem_rdone_addr)
  );

  dram_model dram_model_i (
    .clk_i        (clk_i),
    .core_rst_i   (core_rst),
    .mem_req_v_i  (mem_req_v),
    .mem_req_i    (mem_req),
    .rdata_o      (mem_rdata),
    .rdata_v_o    (mem_rdata_v),
    .rdone_addr_o (mem_rdone_addr)
  );

endmodule

// File: verilog/dram_channel_ctrl.sv
//////////////////////////////
// burst engine between the granted vcache DMA port and the channel
// hashes cache order addresses to channel order on the way out and
// back again on read completion; read data pass a one-entry slot
//////////////////////////////

`timescale 1ns/100ps

module dram_channel_ctrl (
  input  logic                                                clk_i,
  input  logic                                                core_rst_i,
  input  logic                                                req_v_i,
  input  dram_bridge_pkg::dma_pkt_s                           req_pkt_i,
  input  logic [dram_bridge_pkg::CACHE_ID_W-1:0]              req_id_i,
  output logic                                                busy_o,
  input  logic [dram_bridge_pkg::NUM_CACHES-1:0]
               [dram_bridge_pkg::DATA_W-1:0]                  dma_data_i,
  input  logic [dram_bridge_pkg::NUM_CACHES-1:0]              dma_data_v_i,
  output logic [dram_bridge_pkg::NUM_CACHES-1:0]              dma_data_yumi_o,
  output logic [dram_bridge_pkg::DATA_W-1:0]                  dma_data_o,
  output logic [dram_bridge_pkg::NUM_CACHES-1:0]              dma_data_v_o,
  input  logic [dram_bridge_pkg::NUM_CACHES-1:0]              dma_data_ready_i,
  output logic                                                mem_req_v_o,
  output dram_bridge_pkg::dram_req_s                          mem_req_o,
  input  logic [dram_bridge_pkg::DATA_W-1:0]                  mem_rdata_i,
  input  logic                                                mem_rdata_v_i,
  input  dram_bridge_pkg::dram_addr_s                         mem_rdone_addr_i
);

  import dram_bridge_pkg::*;

  // cache order ba-bg-ro-co-bo to channel order ro-bg-ba-co-bo
  function automatic dram_addr_s hash_addr(cache_addr_s a);
    dram_addr_s d;
    d.ro = a.ro;
    d.bg = a.bg;
    d.ba = a.ba;
    d.co = a.co;
    d.bo = a.bo;
    return d;
  endfunction

  function automatic cache_addr_s unhash_addr(dram_addr_s d);
    cache_addr_s a;
    a.ba = d.ba;
    a.bg = d.bg;
    a.ro = d.ro;
    a.co = d.co;
    a.bo = d.bo;
    return a;
  endfunction

  ctrl_state_e             state_r;
  cache_addr_s             base_r;
  logic [CACHE_ID_W-1:0]   owner_r;
  logic [BURST_CNT_W-1:0]  word_cnt_r;
  logic                    issue_done_r;
  logic                    slot_v_r;
  logic                    slot_last_r;
  logic [DATA_W-1:0]       slot_data_r;
  cache_addr_s             word_addr;
  cache_addr_s             rdone_cache;
  logic                    wr_take;
  logic                    rd_issue;
  logic                    owner_ready;
  logic                    slot_pop;

  // column steps through the block, one word per beat
  always_comb begin
    word_addr    = base_r;
    word_addr.co = {base_r.co[CO_W-1:BURST_CNT_W], word_cnt_r};
    word_addr.bo = '0;
  end

  assign rdone_cache = unhash_addr(mem_rdone_addr_i);
  assign owner_ready = dma_data_ready_i[owner_r];
  assign slot_pop    = slot_v_r && owner_ready;
  assign wr_take     = (state_r == WRITE_BURST) && dma_data_v_i[owner_r];

  // a new read must land in a slot that is sure to be empty
  assign rd_issue = (state_r == READ_BURST) && !issue_done_r && !mem_rdata_v_i &&
                    (!slot_v_r || owner_ready);

  assign busy_o      = (state_r != IDLE);
  assign mem_req_v_o = wr_take || rd_issue;

  always_comb begin
    mem_req_o.write_not_read = (state_r == WRITE_BURST);
    mem_req_o.addr           = hash_addr(word_addr);
    mem_req_o.data           = dma_data_i[owner_r];
  end

  always_comb begin
    dma_data_yumi_o          = '0;
    dma_data_yumi_o[owner_r] = wr_take;
    dma_data_v_o             = '0;
    dma_data_v_o[owner_r]    = slot_v_r;
  end

  assign dma_data_o = slot_data_r;

  //////////////////////////////
  // burst FSM
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (core_rst_i) begin
      state_r      <= IDLE;
      word_cnt_r   <= '0;
      issue_done_r <= 1'b0;
    end else begin
      case (state_r)
        IDLE: begin
          word_cnt_r   <= '0;
          issue_done_r <= 1'b0;
          if (req_v_i) begin
            state_r <= req_pkt_i.write_not_read ? WRITE_BURST : READ_BURST;
          end
        end
        WRITE_BURST: begin
          if (wr_take) begin
            word_cnt_r <= word_cnt_r + 1'b1;
            if (word_cnt_r == BURST_CNT_W'(BURST_LEN - 1)) begin
              state_r <= IDLE;
            end
          end
        end
        READ_BURST: begin
          if (rd_issue) begin
            word_cnt_r <= word_cnt_r + 1'b1;
            if (word_cnt_r == BURST_CNT_W'(BURST_LEN - 1)) begin
              issue_done_r <= 1'b1;
            end
          end
          // burst ends once the owner takes the last word
          if (slot_pop && slot_last_r) begin
            state_r <= IDLE;
          end
        end
        default: state_r <= IDLE;
      endcase
    end
  end

  // request and owner captured on acceptance
  always_ff @(posedge clk_i) begin
    if (state_r == IDLE && req_v_i) begin
      base_r  <= cache_addr_s'(req_pkt_i.addr);
      owner_r <= req_id_i;
    end
  end

  //////////////////////////////
  // read return slot
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (core_rst_i) begin
      slot_v_r <= 1'b0;
    end else if (mem_rdata_v_i) begin
      slot_v_r <= 1'b1;
    end else if (slot_pop) begin
      slot_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_rdata_v_i) begin
      slot_data_r <= mem_rdata_i;
      slot_last_r <= (rdone_cache.co[BURST_CNT_W-1:0] == BURST_CNT_W'(BURST_LEN - 1));
    end
  end

endmodule

// File: verilog/dram_model.sv
//////////////////////////////
// behavioral DRAM channel memory
// word array indexed by the channel address; always accepts,
// read data and the read-done address return one cycle later
//////////////////////////////

`timescale 1ns/100ps

module dram_model (
  input  logic                                  clk_i,
  input  logic                                  core_rst_i,
  input  logic                                  mem_req_v_i,
  input  dram_bridge_pkg::dram_req_s            mem_req_i,
  output logic [dram_bridge_pkg::DATA_W-1:0]    rdata_o,
  output logic                                  rdata_v_o,
  output dram_bridge_pkg::dram_addr_s           rdone_addr_o
);

  import dram_bridge_pkg::*;

  localparam int WORD_IDX_W = ADDR_W - BO_W;

  logic [DATA_W-1:0]     mem_r [2**WORD_IDX_W];
  logic [WORD_IDX_W-1:0] word_idx;
  logic                  rd_req;

  // drop the byte offset, ro-bg-ba-co selects the word
  assign word_idx = mem_req_i.addr[ADDR_W-1:BO_W];
  assign rd_req   = mem_req_v_i && !mem_req_i.write_not_read;

  always_ff @(posedge clk_i) begin
    if (mem_req_v_i && mem_req_i.write_not_read) begin
      mem_r[word_idx] <= mem_req_i.data;
    end
    if (rd_req) begin
      rdata_o      <= mem_r[word_idx];
      rdone_addr_o <= mem_req_i.addr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (core_rst_i) begin
      rdata_v_o <= 1'b0;
    end else begin
      rdata_v_o <= rd_req;
    end
  end

endmodule

// File: verilog/reset_sequencer.sv
//////////////////////////////
// tag programming phase followed by a staged core reset release
// tag_done_o rises a fixed number of cycles after rst_i falls,
// core_rst_o follows through a short flop chain
//////////////////////////////

`timescale 1ns/100ps

module reset_sequencer (
  input  logic clk_i,
  input  logic rst_i,
  output logic tag_done_o,
  output logic core_rst_o
);

  import dram_bridge_pkg::*;

  localparam int CNT_W = $clog2(TAG_PROG_CYCLES);

  logic [CNT_W-1:0]       tag_cnt_r;
  logic                   tag_done_r;
  logic [RESET_DEPTH-1:0] rst_chain_r;

  // models the tag master shifting out its programming
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tag_cnt_r  <= '0;
      tag_done_r <= 1'b0;
    end else if (!tag_done_r) begin
      tag_cnt_r <= tag_cnt_r + 1'b1;
      if (tag_cnt_r == CNT_W'(TAG_PROG_CYCLES - 1)) begin
        tag_done_r <= 1'b1;
      end
    end
  end

  // core stays in reset until the inverted done flag clears the chain
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rst_chain_r <= '1;
    end else begin
      rst_chain_r <= {rst_chain_r[RESET_DEPTH-2:0], ~tag_done_r};
    end
  end

  assign tag_done_o = tag_done_r;
  assign core_rst_o = rst_chain_r[RESET_DEPTH-1];

endmodule
